// File: Bender.yml
package:
  name: pc_io_hub

sources:
  - files:
      - src/pc_io_pkg.sv
      - src/io_decode.sv
      - src/io_read_mux.sv
      - src/sysctl_port.sv
      - src/mgmt_decode.sv
      - src/ps2_clk_div.sv
      - src/pc_io_hub.sv
  - target: test
    files:
      - tests/pc_io_hub_chk.sv
      - tests/pc_io_hub_tb.sv

// File: src/io_decode.sv
/* port address decoder: registered chip selects for the PC devices
   and the 32-bit access flag */
`timescale 1ns/1ps

module io_decode (
	input  logic                clk_sys,
	input  logic                reset,
	input  pc_io_pkg::io_addr_t io_address,
	output pc_io_pkg::dev_sel_t dev_sel,
	output logic                io_32
);

	import pc_io_pkg::*;

	dev_sel_t sel_next;

	always_comb begin
		sel_next = '0;

		// disk controllers, data block plus control register
		sel_next[SEL_IDE0] = ({io_address[15:3], 3'd0} == 16'h01F0) ||
			(io_address == 16'h03F6);
		sel_next[SEL_IDE1] = ({io_address[15:3], 3'd0} == 16'h0170) ||
			(io_address == 16'h0376);
		sel_next[SEL_FLOPPY] = ({io_address[15:2], 2'd0} == 16'h03F0) ||
			({io_address[15:1], 1'b0} == 16'h03F4) ||
			(io_address == 16'h03F7);

		// master and slave dma share one select
		sel_next[SEL_DMA] = ({io_address[15:5], 5'd0} == 16'h00C0) ||
			({io_address[15:4], 4'd0} == 16'h0000);
		sel_next[SEL_DMA_PAGE] = ({io_address[15:4], 4'd0} == 16'h0080);

		sel_next[SEL_PIC] = ({io_address[15:1], 1'b0} == 16'h0020) ||
			({io_address[15:1], 1'b0} == 16'h00A0);
		// counters plus the speaker gate at 0x61
		sel_next[SEL_PIT] = ({io_address[15:2], 2'd0} == 16'h0040) ||
			(io_address == 16'h0061);

		// keyboard block minus port b at 0x61
		sel_next[SEL_PS2]     = ({io_address[15:3], 3'd0} == 16'h0060) &&
			(io_address != 16'h0061);
		sel_next[SEL_PS2_CTL] = ({io_address[15:4], 4'd0} == 16'h0090);
		sel_next[SEL_RTC]     = ({io_address[15:1], 1'b0} == 16'h0070);

		// mono, colour and crtc blocks 0x3b0 to 0x3df
		sel_next[SEL_VGA] = ({io_address[15:4], 4'd0} == 16'h03B0) ||
			({io_address[15:4], 4'd0} == 16'h03C0) ||
			({io_address[15:4], 4'd0} == 16'h03D0);

		sel_next[SEL_SYSCTL] = (io_address == SYSCTL_PORT);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dev_sel <= '0;
		end else begin
			dev_sel <= sel_next;
		end
	end

	// ide data ports are 32 bit, control ports at bit 9 are not
	assign io_32 = ((dev_sel[SEL_IDE0] | dev_sel[SEL_IDE1]) & ~io_address[9]) |
		dev_sel[SEL_SYSCTL];

endmodule

// File: src/io_read_mux.sv
/* read data merge: fixed priority pick of the device read data
   onto the 32-bit bus read value */
`timescale 1ns/1ps

module io_read_mux (
	input  pc_io_pkg::dev_sel_t dev_sel,
	input  pc_io_pkg::io_data_t ide0_rdata,
	input  pc_io_pkg::io_data_t ide1_rdata,
	input  pc_io_pkg::io_byte_t floppy_rdata,
	input  pc_io_pkg::io_byte_t dma_rdata,
	input  pc_io_pkg::io_byte_t pic_rdata,
	input  pc_io_pkg::io_byte_t pit_rdata,
	input  pc_io_pkg::io_byte_t ps2_rdata,
	input  pc_io_pkg::io_byte_t rtc_rdata,
	input  pc_io_pkg::io_byte_t vga_rdata,
	output pc_io_pkg::io_data_t io_readdata
);

	import pc_io_pkg::*;

	io_byte_t rdata8;

	// 8-bit devices first
	always_comb begin
		if (dev_sel[SEL_FLOPPY]) begin
			rdata8 = floppy_rdata;
		end else if (dev_sel[SEL_DMA] | dev_sel[SEL_DMA_PAGE]) begin
			rdata8 = dma_rdata;
		end else if (dev_sel[SEL_PIC]) begin
			rdata8 = pic_rdata;
		end else if (dev_sel[SEL_PIT]) begin
			rdata8 = pit_rdata;
		end else if (dev_sel[SEL_PS2] | dev_sel[SEL_PS2_CTL]) begin
			rdata8 = ps2_rdata;
		end else if (dev_sel[SEL_RTC]) begin
			rdata8 = rtc_rdata;
		end else if (dev_sel[SEL_VGA]) begin
			rdata8 = vga_rdata;
		end else begin
			rdata8 = IO_UNMAPPED;
		end
	end

	// ide controllers win over everything, full width
	always_comb begin
		if (dev_sel[SEL_IDE0]) begin
			io_readdata = ide0_rdata;
		end else if (dev_sel[SEL_IDE1]) begin
			io_readdata = ide1_rdata;
		end else begin
			io_readdata = {24'd0, rdata8};
		end
	end

endmodule

// File: src/mgmt_decode.sv
/* management bus decode: page strobes for the disk and rtc targets
   and the read data merge */
`timescale 1ns/1ps

module mgmt_decode (
	input  pc_io_pkg::mgmt_addr_t  mgmt_address,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  pc_io_pkg::mgmt_rdata_t mgmt_ide0_rdata,
	input  pc_io_pkg::mgmt_rdata_t mgmt_ide1_rdata,
	input  pc_io_pkg::mgmt_rdata_t mgmt_fdd_rdata,
	output logic                   mgmt_ide0_write,
	output logic                   mgmt_ide1_write,
	output logic                   mgmt_fdd_write,
	output logic                   mgmt_fdd_read,
	output logic                   mgmt_rtc_write,
	output pc_io_pkg::mgmt_data_t  mgmt_readdata
);

	import pc_io_pkg::*;

	logic [7:0] page;
	logic       ide0_hit;
	logic       ide1_hit;
	logic       fdd_hit;
	logic       rtc_hit;

	assign page = mgmt_address[15:8];

	assign ide0_hit = (page == MGMT_PAGE_IDE0);
	assign ide1_hit = (page == MGMT_PAGE_IDE1);
	assign fdd_hit  = (page == MGMT_PAGE_FDD);
	assign rtc_hit  = (page == MGMT_PAGE_RTC);

	assign mgmt_ide0_write = mgmt_write & ide0_hit;
	assign mgmt_ide1_write = mgmt_write & ide1_hit;
	assign mgmt_fdd_write  = mgmt_write & fdd_hit;
	assign mgmt_rtc_write  = mgmt_write & rtc_hit;
	// only the floppy target is read back through a strobe
	assign mgmt_fdd_read   = mgmt_read & fdd_hit;

	// fdd data is the default, any other page reads it too
	assign mgmt_readdata = ide0_hit ? {16'd0, mgmt_ide0_rdata} :
		ide1_hit ? {16'd0, mgmt_ide1_rdata} :
		{16'd0, mgmt_fdd_rdata};

endmodule

// File: src/pc_io_hub.sv
/* I/O glue of the PC system: port decode, read merge, control port,
   management decode and PS/2 clock divider */
`timescale 1ns/1ps

module pc_io_hub #(
	parameter int unsigned PS2_DIV = 2000
) (
	input  logic                   clk_sys,
	input  logic                   reset,

	// cpu side port bus
	input  pc_io_pkg::io_addr_t    io_address,
	input  logic                   io_read,
	input  logic                   io_write,
	input  pc_io_pkg::io_size_t    io_datasize,
	input  pc_io_pkg::io_data_t    io_writedata,
	output pc_io_pkg::io_data_t    io_readdata,
	output logic                   io_32,
	output pc_io_pkg::dev_sel_t    dev_sel,

	// device read data
	input  pc_io_pkg::io_data_t    ide0_rdata,
	input  pc_io_pkg::io_data_t    ide1_rdata,
	input  pc_io_pkg::io_byte_t    floppy_rdata,
	input  pc_io_pkg::io_byte_t    dma_rdata,
	input  pc_io_pkg::io_byte_t    pic_rdata,
	input  pc_io_pkg::io_byte_t    pit_rdata,
	input  pc_io_pkg::io_byte_t    ps2_rdata,
	input  pc_io_pkg::io_byte_t    rtc_rdata,
	input  pc_io_pkg::io_byte_t    vga_rdata,

	// management host and targets
	input  pc_io_pkg::mgmt_addr_t  mgmt_address,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  pc_io_pkg::mgmt_data_t  mgmt_writedata,
	output pc_io_pkg::mgmt_data_t  mgmt_readdata,
	input  pc_io_pkg::mgmt_rdata_t mgmt_ide0_rdata,
	input  pc_io_pkg::mgmt_rdata_t mgmt_ide1_rdata,
	input  pc_io_pkg::mgmt_rdata_t mgmt_fdd_rdata,
	output logic                   mgmt_ide0_write,
	output logic                   mgmt_ide1_write,
	output logic                   mgmt_fdd_write,
	output logic                   mgmt_fdd_read,
	output logic                   mgmt_rtc_write,

	output pc_io_pkg::io_byte_t    syscfg,
	output logic                   ps2_clk
);

	// io_read and mgmt_writedata reach the devices straight from the host

	io_decode i_io_decode (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_address (io_address),
		.dev_sel    (dev_sel),
		.io_32      (io_32)
	);

	io_read_mux i_io_read_mux (
		.dev_sel      (dev_sel),
		.ide0_rdata   (ide0_rdata),
		.ide1_rdata   (ide1_rdata),
		.floppy_rdata (floppy_rdata),
		.dma_rdata    (dma_rdata),
		.pic_rdata    (pic_rdata),
		.pit_rdata    (pit_rdata),
		.ps2_rdata    (ps2_rdata),
		.rtc_rdata    (rtc_rdata),
		.vga_rdata    (vga_rdata),
		.io_readdata  (io_readdata)
	);

	sysctl_port i_sysctl_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dev_sel      (dev_sel),
		.io_write     (io_write),
		.io_datasize  (io_datasize),
		.io_writedata (io_writedata),
		.syscfg       (syscfg)
	);

	mgmt_decode i_mgmt_decode (
		.mgmt_address    (mgmt_address),
		.mgmt_read       (mgmt_read),
		.mgmt_write      (mgmt_write),
		.mgmt_ide0_rdata (mgmt_ide0_rdata),
		.mgmt_ide1_rdata (mgmt_ide1_rdata),
		.mgmt_fdd_rdata  (mgmt_fdd_rdata),
		.mgmt_ide0_write (mgmt_ide0_write),
		.mgmt_ide1_write (mgmt_ide1_write),
		.mgmt_fdd_write  (mgmt_fdd_write),
		.mgmt_fdd_read   (mgmt_fdd_read),
		.mgmt_rtc_write  (mgmt_rtc_write),
		.mgmt_readdata   (mgmt_readdata)
	);

	ps2_clk_div #(
		.DIV (PS2_DIV)
	) i_ps2_clk_div (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_clk (ps2_clk)
	);

endmodule

// File: src/pc_io_pkg.sv
/* bus and management types, device select indices, port constants
   and the control port state enum */
package pc_io_pkg;

	// port I/O bus
	typedef logic [15:0] io_addr_t;
	typedef logic [31:0] io_data_t;
	typedef logic [7:0]  io_byte_t;
	typedef logic [2:0]  io_size_t;

	// management bus
	typedef logic [15:0] mgmt_addr_t;
	typedef logic [31:0] mgmt_data_t;
	typedef logic [15:0] mgmt_rdata_t;

	// one select bit per decoded device
	localparam int NUM_SEL = 12;

	typedef logic [NUM_SEL-1:0] dev_sel_t;

	localparam int SEL_IDE0     = 0;
	localparam int SEL_IDE1     = 1;
	localparam int SEL_FLOPPY   = 2;
	localparam int SEL_DMA      = 3;
	localparam int SEL_PIC      = 4;
	localparam int SEL_PIT      = 5;
	localparam int SEL_PS2      = 6;
	localparam int SEL_RTC      = 7;
	localparam int SEL_VGA      = 8;
	localparam int SEL_SYSCTL   = 9;
	localparam int SEL_DMA_PAGE = 10;
	localparam int SEL_PS2_CTL  = 11;

	// system control port
	localparam io_addr_t SYSCTL_PORT  = 16'h8888;
	localparam io_byte_t SYSCFG_RESET = 8'hA2;
	localparam io_byte_t SYSCTL_KEY   = 8'hA1;
	localparam io_size_t SYSCTL_SIZE  = 3'd2;

	// floating bus value
	localparam io_byte_t IO_UNMAPPED = 8'hFF;

	// management pages, top address byte
	localparam logic [7:0] MGMT_PAGE_IDE0 = 8'hF0;
	localparam logic [7:0] MGMT_PAGE_IDE1 = 8'hF1;
	localparam logic [7:0] MGMT_PAGE_FDD  = 8'hF2;
	localparam logic [7:0] MGMT_PAGE_RTC  = 8'hF4;

	// held until the first disk access or a keyed write
	typedef enum logic {
		boot_hold,
		running
	} sysctl_state_t;

endpackage

// File: src/ps2_clk_div.sv
/* divider for the emulated PS/2 clock */
`timescale 1ns/1ps

module ps2_clk_div #(
	parameter int unsigned DIV = 2000
) (
	input  logic clk_sys,
	input  logic reset,
	output logic ps2_clk
);

	localparam int CNT_W = $clog2(DIV + 1);

	logic [CNT_W-1:0] cnt;

	// toggles once every DIV+1 system clocks
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt     <= '0;
			ps2_clk <= 1'b0;
		end else if (cnt == CNT_W'(DIV)) begin
			cnt     <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: src/sysctl_port.sv
/* system control port: config byte with keyed writes and
   the boot hold state machine */
`timescale 1ns/1ps

module sysctl_port (
	input  logic                clk_sys,
	input  logic                reset,
	input  pc_io_pkg::dev_sel_t dev_sel,
	input  logic                io_write,
	input  pc_io_pkg::io_size_t io_datasize,
	input  pc_io_pkg::io_data_t io_writedata,
	output pc_io_pkg::io_byte_t syscfg
);

	import pc_io_pkg::*;

	sysctl_state_t state;
	logic          key_write;
	logic          disk_sel;

	// word write with the key in the upper byte
	assign key_write = io_write && dev_sel[SEL_SYSCTL] &&
		(io_datasize == SYSCTL_SIZE) && (io_writedata[15:8] == SYSCTL_KEY);

	assign disk_sel = dev_sel[SEL_IDE0] | dev_sel[SEL_IDE1] | dev_sel[SEL_FLOPPY];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= boot_hold;
			syscfg <= SYSCFG_RESET;
		end else begin
			case (state)
				boot_hold: begin
					// bios touching a disk means boot is under way
					if (disk_sel) begin
						syscfg <= '0;
						state  <= running;
					end else if (key_write) begin
						syscfg <= io_writedata[7:0];
						state  <= running;
					end
				end
				running: begin
					if (key_write) begin
						syscfg <= io_writedata[7:0];
					end
				end
				default: begin
					state <= boot_hold;
				end
			endcase
		end
	end

endmodule

// File: tests/io_patterns.txt
// kind_address_wdata_size_sel_io32_syscfg; kind 0 io read, 1 io write, 2 mgmt, F end marker
// sel is the select index or F for none; mgmt uses size 1 read, 2 write, sel the page target
0_0060_00000000_1_6_0_A2
0_0021_00000000_1_4_0_A2
0_00A0_00000000_1_4_0_A2
0_0043_00000000_1_5_0_A2
0_0061_00000000_1_5_0_A2
0_0071_00000000_1_7_0_A2
0_03C5_00000000_1_8_0_A2
0_00C4_00000000_1_3_0_A2
0_0005_00000000_1_3_0_A2
0_0083_00000000_1_A_0_A2
0_0094_00000000_1_B_0_A2
0_0300_00000000_1_F_0_A2
1_8888_0000B155_2_9_1_A2
0_03F5_00000000_1_2_0_00
1_8888_0000A13C_2_9_1_3C
1_8888_0000A177_1_9_1_3C
0_01F0_00000000_4_0_1_3C
0_03F6_00000000_1_0_0_3C
0_0174_00000000_4_1_1_3C
0_0376_00000000_1_1_0_3C
0_03F7_00000000_1_2_0_3C
2_F012_00001111_2_0_0_3C
2_F134_00002222_2_1_0_3C
2_F256_00000000_1_2_0_3C
2_F278_00003333_2_2_0_3C
2_F4AA_00004444_2_4_0_3C
2_12CD_00005555_2_F_0_3C
2_1234_00000000_1_F_0_3C
F_0000_00000000_0_F_0_00

// File: tests/pc_io_hub_chk.sv
/* bound assertions on the hub: one-hot device selects and gated
   management strobes */
`timescale 1ns/1ps

module pc_io_hub_chk (
	input logic                clk_sys,
	input logic                reset,
	input pc_io_pkg::dev_sel_t dev_sel,
	input logic                mgmt_read,
	input logic                mgmt_write,
	input logic                mgmt_ide0_write,
	input logic                mgmt_ide1_write,
	input logic                mgmt_fdd_write,
	input logic                mgmt_fdd_read,
	input logic                mgmt_rtc_write
);

	// at most one device answers a port
	a_sel_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(dev_sel))
		else $error("dev_sel has more than one bit set: %b", dev_sel);

	a_write_gated: assert property (@(posedge clk_sys) disable iff (reset)
		(mgmt_ide0_write | mgmt_ide1_write | mgmt_fdd_write | mgmt_rtc_write) |-> mgmt_write)
		else $error("management write strobe without mgmt_write");

	a_read_gated: assert property (@(posedge clk_sys) disable iff (reset)
		mgmt_fdd_read |-> mgmt_read)
		else $error("management read strobe without mgmt_read");

endmodule

// File: tests/pc_io_hub_tb.sv
/* testbench for the PC I/O hub: pattern driven port and management
   accesses, control port and PS/2 clock checks */
`timescale 1ns/1ps

module pc_io_hub_tb;

	import pc_io_pkg::*;

	localparam int MAX_PAT = 64;
	localparam int PS2_DIV = 5;

	logic        clk_sys;
	logic        reset;
	io_addr_t    io_address;
	logic        io_read, io_write;
	io_size_t    io_datasize;
	io_data_t    io_writedata, io_readdata;
	logic        io_32;
	dev_sel_t    dev_sel;
	io_data_t    ide0_rdata, ide1_rdata;
	io_byte_t    floppy_rdata, dma_rdata, pic_rdata, pit_rdata, ps2_rdata, rtc_rdata, vga_rdata;
	mgmt_addr_t  mgmt_address;
	logic        mgmt_read, mgmt_write;
	mgmt_data_t  mgmt_writedata, mgmt_readdata;
	mgmt_rdata_t mgmt_ide0_rdata, mgmt_ide1_rdata, mgmt_fdd_rdata;
	logic        mgmt_ide0_write, mgmt_ide1_write, mgmt_fdd_write, mgmt_fdd_read, mgmt_rtc_write;
	io_byte_t    syscfg;
	logic        ps2_clk;

	// kind, address, wdata, size, sel, io_32, syscfg
	logic [71:0] pat_mem [0:MAX_PAT-1];
	int          n_pat, n_cycles, ps2_edges;
	int          cycle_limit = MAX_PAT * 4 + 200;

	pc_io_hub #(.PS2_DIV(PS2_DIV)) i_dut (.*);

	bind pc_io_hub pc_io_hub_chk i_chk (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic stop_failed();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic check_sel(input string name, input dev_sel_t got, input dev_sel_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_data(input string name, input io_data_t got, input io_data_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_byte(input string name, input io_byte_t got, input io_byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_mgmt(input string name, input mgmt_data_t got, input mgmt_data_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
			stop_failed();
		end
	endtask

	function automatic dev_sel_t sel_onehot(input logic [3:0] idx);
		dev_sel_t s;
		s = '0;
		if (idx != 4'hF) begin
			s[idx] = 1'b1;
		end
		return s;
	endfunction

	// priority pick of the port map, reduced to the single expected device
	function automatic io_data_t expected_read(input logic [3:0] idx);
		case (idx)
			SEL_IDE0:              return ide0_rdata;
			SEL_IDE1:              return ide1_rdata;
			SEL_FLOPPY:            return {24'd0, floppy_rdata};
			SEL_DMA, SEL_DMA_PAGE: return {24'd0, dma_rdata};
			SEL_PIC:               return {24'd0, pic_rdata};
			SEL_PIT:               return {24'd0, pit_rdata};
			SEL_PS2, SEL_PS2_CTL:  return {24'd0, ps2_rdata};
			SEL_RTC:               return {24'd0, rtc_rdata};
			SEL_VGA:               return {24'd0, vga_rdata};
			default:               return 32'h0000_00FF;
		endcase
	endfunction

	task automatic randomize_sources();
		ide0_rdata      = $urandom;
		ide1_rdata      = $urandom;
		floppy_rdata    = io_byte_t'($urandom);
		dma_rdata       = io_byte_t'($urandom);
		pic_rdata       = io_byte_t'($urandom);
		pit_rdata       = io_byte_t'($urandom);
		ps2_rdata       = io_byte_t'($urandom);
		rtc_rdata       = io_byte_t'($urandom);
		vga_rdata       = io_byte_t'($urandom);
		mgmt_ide0_rdata = mgmt_rdata_t'($urandom);
		mgmt_ide1_rdata = mgmt_rdata_t'($urandom);
		mgmt_fdd_rdata  = mgmt_rdata_t'($urandom);
	endtask

	// address cycle, then strobe cycle while the select is valid
	task automatic run_io(input logic [71:0] p);
		logic [3:0] sel;
		sel = p[15:12];
		@(posedge clk_sys);
		#2;
		io_address = p[67:52];
		randomize_sources();
		@(posedge clk_sys);
		#2;
		io_read      = (p[71:68] == 4'h0);
		io_write     = (p[71:68] == 4'h1);
		io_writedata = p[51:20];
		io_datasize  = p[18:16];
		@(negedge clk_sys);
		check_sel("dev_sel", dev_sel, sel_onehot(sel));
		check_data("io_readdata", io_readdata, expected_read(sel));
		check_bit("io_32", io_32, p[8]);
		@(posedge clk_sys);
		#2;
		io_read  = 1'b0;
		io_write = 1'b0;
		@(negedge clk_sys);
		check_byte("syscfg", syscfg, p[7:0]);
	endtask

	task automatic run_mgmt(input logic [71:0] p);
		logic [3:0] tgt;
		tgt = p[15:12];
		@(posedge clk_sys);
		#2;
		io_address     = 16'h0300;
		mgmt_address   = p[67:52];
		mgmt_writedata = p[51:20];
		mgmt_read      = p[16];
		mgmt_write     = p[17];
		randomize_sources();
		@(negedge clk_sys);
		check_bit("mgmt_ide0_write", mgmt_ide0_write, mgmt_write && tgt == 4'h0);
		check_bit("mgmt_ide1_write", mgmt_ide1_write, mgmt_write && tgt == 4'h1);
		check_bit("mgmt_fdd_write", mgmt_fdd_write, mgmt_write && tgt == 4'h2);
		check_bit("mgmt_rtc_write", mgmt_rtc_write, mgmt_write && tgt == 4'h4);
		check_bit("mgmt_fdd_read", mgmt_fdd_read, mgmt_read && tgt == 4'h2);
		check_mgmt("mgmt_readdata", mgmt_readdata, (tgt == 4'h0) ? {16'd0, mgmt_ide0_rdata} :
			(tgt == 4'h1) ? {16'd0, mgmt_ide1_rdata} : {16'd0, mgmt_fdd_rdata});
		check_byte("syscfg", syscfg, p[7:0]);
		@(posedge clk_sys);
		#2;
		mgmt_read  = 1'b0;
		mgmt_write = 1'b0;
	endtask

	// ps2_clk flips every PS2_DIV+1 edges counted from reset release
	always @(posedge clk_sys) begin
		ps2_edges <= reset ? 0 : ps2_edges + 1;
	end

	always @(negedge clk_sys) begin
		if (!reset) begin
			check_bit("ps2_clk", ps2_clk, logic'((ps2_edges / (PS2_DIV + 1)) % 2));
		end
	end

	always @(posedge clk_sys) begin
		n_cycles++;
		if (n_cycles > cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", n_cycles);
			stop_failed();
		end
	end

	initial begin
		void'($urandom(32'ha621));
		reset          = 1'b1;
		io_address     = 16'h0300;
		io_read        = 1'b0;
		io_write       = 1'b0;
		io_datasize    = '0;
		io_writedata   = '0;
		mgmt_address   = '0;
		mgmt_read      = 1'b0;
		mgmt_write     = 1'b0;
		mgmt_writedata = '0;
		randomize_sources();
		$readmemh("tests/io_patterns.txt", pat_mem);
		n_pat = 0;
		while (n_pat < MAX_PAT && pat_mem[n_pat][71:68] !== 4'hF &&
			!$isunknown(pat_mem[n_pat])) begin
			n_pat++;
		end
		if (n_pat == 0 || pat_mem[n_pat][71:68] !== 4'hF) begin
			$display("pattern file is missing, empty or has no end marker");
			stop_failed();
		end
		cycle_limit = n_pat * 4 + 200;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		@(negedge clk_sys);
		check_sel("dev_sel", dev_sel, '0);
		check_byte("syscfg", syscfg, 8'hA2);
		for (int i = 0; i < n_pat; i++) begin
			case (pat_mem[i][71:68])
				4'h0, 4'h1: run_io(pat_mem[i]);
				4'h2:       run_mgmt(pat_mem[i]);
				default: begin
					$display("pattern %0d has an unknown access kind", i);
					stop_failed();
				end
			endcase
		end
		// a few more divider periods for the ps2 monitor
		repeat (4 * (PS2_DIV + 1)) @(posedge clk_sys);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: vlog.f
src/pc_io_pkg.sv
src/io_decode.sv
src/io_read_mux.sv
src/sysctl_port.sv
src/mgmt_decode.sv
src/ps2_clk_div.sv
src/pc_io_hub.sv
tests/pc_io_hub_chk.sv
tests/pc_io_hub_tb.sv
